/* bench/lsu_testdata.txt */
# op  addr     wdata    gpi rsp      gpo
# rsp is the expected load data or - for a store, gpo the pin value after the request
SW  00008000 12345678 0 -        0
LW  00008000 00000000 0 12345678 0
SB  00008001 000000ab 0 -        0
SB  00008002 000000cd 0 -        0
SB  00008003 000000ef 0 -        0
SB  00008000 00000001 0 -        0
LW  00008000 00000000 0 efcdab01 0
SH  00008004 0000beef 0 -        0
SH  00008006 00008001 0 -        0
SH  00008005 00001234 0 -        0
SH  00008007 0000ffff 0 -        0
LW  00008004 00000000 0 801234ef 0
LB  00008000 00000000 0 00000001 0
LB  00008001 00000000 0 ffffffab 0
LBU 00008002 00000000 0 000000cd 0
LB  00008003 00000000 0 ffffffef 0
LH  00008000 00000000 0 ffffab01 0
LHU 00008001 00000000 0 0000cdab 0
LH  00008002 00000000 0 ffffefcd 0
LH  00008003 00000000 0 ffffab01 0
LHU 00008003 00000000 0 0000ab01 0
LH  00008006 00000000 0 ffff8012 0
SW  0000f004 0000000a 0 -        a
LW  0000f004 00000000 0 0000000a a
SB  0000f004 00000035 0 -        5
SW  0000f000 0000000f 0 -        5
LW  0000f004 00000000 0 00000005 5
LW  0000f000 00000000 9 00000009 5
LB  0000f000 00000000 9 00000000 5
LW  0000f000 00000000 3 00000003 5
LW  00001000 00000000 3 00000000 5
SW  00009000 deadbeef 3 -        5
SW  00007ffc 11111111 3 -        5
LW  00008000 00000000 3 efcdab01 5
SW  00008ffc cafef00d 3 -        5
LW  00008ffc 00000000 3 cafef00d 5
LW  0000f008 00000000 3 00000000 5

/* files.f */
+incdir+src
+incdir+bench
src/mem_map_pkg.sv
src/lsu_types_pkg.sv
src/store_aligner.sv
src/dmem_lane.sv
src/mmio_regs.sv
src/load_extractor.sv
src/lsu_top.sv
bench/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv bench/*.svh) $(FILELIST)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* bench/lsu_tb_checks.svh */
// ====================
// compare tasks for load data and output pins
// ====================

`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

task automatic check_load(input lsu_types_pkg::word_t got, input lsu_types_pkg::word_t exp,
                          input int idx);
    check_count++;
    if (got !== exp) begin
        $display("Mismatch at %0t: test %0d load data %h, expected %h", $time, idx, got, exp);
        err_count++;
    end
endtask

task automatic check_gpo(input mem_map_pkg::gpio_t got, input mem_map_pkg::gpio_t exp,
                         input int idx);
    check_count++;
    if (got !== exp) begin
        $display("Mismatch at %0t: test %0d gpo pins %h, expected %h", $time, idx, got, exp);
        err_count++;
    end
endtask

`endif

/* bench/lsu_tb.sv */
// ====================
// testbench for lsu_top, requests and
// expected results come from the test data file
// ====================

`default_nettype none

module lsu_tb;

    typedef struct packed {
        lsu_types_pkg::lsu_op_e op;
        lsu_types_pkg::word_t   addr;
        lsu_types_pkg::word_t   wdata;
        mem_map_pkg::gpio_t     gpi;
        logic                   is_load;
        lsu_types_pkg::word_t   exp_rsp;
        mem_map_pkg::gpio_t     exp_gpo;
    } test_t;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    lsu_types_pkg::lsu_req_t req;
    mem_map_pkg::gpio_t      gpi;
    mem_map_pkg::gpio_t      gpo;
    logic                    rsp_valid;
    lsu_types_pkg::word_t    rsp_data;

    test_t tests[$];
    test_t prev_t;
    bit    prev_live = 1'b0;
    int    prev_idx = -1;
    int    err_count = 0;
    int    check_count = 0;
    int    pass_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    `include "lsu_tb_checks.svh"

    lsu_top lsu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .gpi       (gpi),
        .gpo       (gpo),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // limit is set once the test data is read
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    function automatic bit op_from_name(input string name, output lsu_types_pkg::lsu_op_e op);
        op = lsu_types_pkg::OP_LW;
        case (name)
            "LB":    op = lsu_types_pkg::OP_LB;
            "LH":    op = lsu_types_pkg::OP_LH;
            "LW":    op = lsu_types_pkg::OP_LW;
            "LBU":   op = lsu_types_pkg::OP_LBU;
            "LHU":   op = lsu_types_pkg::OP_LHU;
            "SB":    op = lsu_types_pkg::OP_SB;
            "SH":    op = lsu_types_pkg::OP_SH;
            "SW":    op = lsu_types_pkg::OP_SW;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic read_tests();
        int                     fd;
        int                     n;
        bit                     ok;
        string                  line;
        string                  op_name;
        string                  rsp_tok;
        test_t                  t;
        lsu_types_pkg::lsu_op_e op_v;
        lsu_types_pkg::word_t   addr_v;
        lsu_types_pkg::word_t   wdata_v;
        lsu_types_pkg::word_t   exp_v;
        mem_map_pkg::gpio_t     gpi_v;
        mem_map_pkg::gpio_t     gpo_v;
        fd = $fopen("bench/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/lsu_testdata.txt");
            err_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %s %h", op_name, addr_v, wdata_v, gpi_v, rsp_tok,
                        gpo_v);
            ok = op_from_name(op_name, op_v);
            if (n != 6 || !ok) begin
                $write("unreadable test data line: %s", line);
                err_count++;
            end else begin
                exp_v = '0;
                if (rsp_tok != "-") begin
                    void'($sscanf(rsp_tok, "%h", exp_v));
                end
                t = '{op: op_v, addr: addr_v, wdata: wdata_v, gpi: gpi_v,
                      is_load: (rsp_tok != "-"), exp_rsp: exp_v, exp_gpo: gpo_v};
                tests.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    // ====================
    // per-cycle drive and check
    // ====================

    // response and gpo for last cycle's request are settled by the falling edge
    task automatic step(input bit live, input test_t t, input int idx);
        int errs_before;
        @(posedge clk);
        req_valid <= live;
        if (live) begin
            req <= '{op: t.op, addr: t.addr, wdata: t.wdata};
            gpi <= t.gpi;
        end
        @(negedge clk);
        errs_before = err_count;
        if (prev_live && prev_t.is_load) begin
            if (rsp_valid !== 1'b1) begin
                $display("test %0d: no load response one cycle after the request", prev_idx);
                err_count++;
            end else begin
                check_load(rsp_data, prev_t.exp_rsp, prev_idx);
            end
        end else if (rsp_valid !== 1'b0) begin
            $display("response at %0t with no load strobed one cycle earlier", $time);
            err_count++;
        end
        if (prev_live) begin
            check_gpo(gpo, prev_t.exp_gpo, prev_idx);
            if (err_count == errs_before) begin
                pass_count++;
            end
            $display("test %0d %s addr %h: %s", prev_idx, prev_t.op.name(), prev_t.addr,
                     (err_count == errs_before) ? "ok" : "failed");
        end
        prev_live = live;
        prev_t    = t;
        prev_idx  = idx;
    endtask

    task automatic run_tests();
        test_t idle;
        int    gap;
        idle = '0;
        foreach (tests[i]) begin
            step(1'b1, tests[i], i);
            gap = 0;
            // idle gaps on about a third of the requests, the rest back to back
            if ($urandom_range(2, 0) == 0) begin
                gap = int'($urandom_range(2, 0));
            end
            repeat (gap) step(1'b0, idle, -1);
        end
        step(1'b0, idle, -1);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        gpi       = '0;
        void'($urandom(32'h6395_bf5f));
        read_tests();
        if (tests.size() == 0) begin
            $display("no tests read from the test data file");
            err_count++;
        end
        cycle_limit = tests.size() * 4 + 100;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        run_tests();
        $display("%0d tests, %0d passed, %0d checks, %0d errors", tests.size(), pass_count,
                 check_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
// ====================
// load/store unit top level
// ====================

`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    req_valid,
    input  wire lsu_types_pkg::lsu_req_t req,
    input  wire mem_map_pkg::gpio_t      gpi,
    output mem_map_pkg::gpio_t           gpo,
    output logic                         rsp_valid,
    output lsu_types_pkg::word_t         rsp_data
);

    lsu_types_pkg::lane_wr_t       lane_wr;
    lsu_types_pkg::pend_load_t     pend;
    logic [`LSU_LANES-1:0][7:0]    lane_rdata;
    logic                          gpo_we;
    mem_map_pkg::gpio_t            gpo_data;
    mem_map_pkg::gpio_t            gpi_q;
    mem_map_pkg::gpio_t            gpo_q;

    store_aligner store_aligner_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .lane_wr   (lane_wr),
        .gpo_we    (gpo_we),
        .gpo_data  (gpo_data),
        .pend      (pend)
    );

    // one bank per byte lane
    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        dmem_lane dmem_lane_inst (
            .clk   (clk),
            .we    (lane_wr.we[i]),
            .addr  (lane_wr.addr),
            .wdata (lane_wr.data[i]),
            .rdata (lane_rdata[i])
        );
    end

    mmio_regs mmio_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .gpi      (gpi),
        .gpo_we   (gpo_we),
        .gpo_data (gpo_data),
        .gpi_q    (gpi_q),
        .gpo_q    (gpo_q)
    );

    load_extractor load_extractor_inst (
        .pend       (pend),
        .lane_rdata (lane_rdata),
        .gpi_q      (gpi_q),
        .gpo_q      (gpo_q),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    assign gpo = gpo_q;

endmodule

`default_nettype wire

/* src/load_extractor.sv */
// ====================
// load lane select, extension
// and I/O readback
// ====================

`default_nettype none

`include "lsu_macros.svh"

module load_extractor (
    input  wire lsu_types_pkg::pend_load_t        pend,
    input  wire logic [`LSU_LANES-1:0][7:0]       lane_rdata,
    input  wire mem_map_pkg::gpio_t               gpi_q,
    input  wire mem_map_pkg::gpio_t               gpo_q,
    output logic                                  rsp_valid,
    output lsu_types_pkg::word_t                  rsp_data
);

    logic [15:0] sel_half;
    logic [7:0]  sel_byte;
    logic        is_lw;

    assign rsp_valid = pend.valid;
    assign is_lw     = (pend.op == lsu_types_pkg::OP_LW);

    // offset 3 halfword falls back to lanes 1 and 0
    always_comb begin
        case (pend.offset)
            2'd1:    sel_half = {lane_rdata[2], lane_rdata[1]};
            2'd2:    sel_half = {lane_rdata[3], lane_rdata[2]};
            default: sel_half = {lane_rdata[1], lane_rdata[0]};
        endcase
        sel_byte = lane_rdata[pend.offset];
    end

    // ====================
    // response mux
    // ====================

    always_comb begin
        rsp_data = '0;
        case (pend.region)
            mem_map_pkg::REGION_DMEM: begin
                case (pend.op)
                    lsu_types_pkg::OP_LB:  rsp_data = {{24{sel_byte[7]}}, sel_byte};
                    lsu_types_pkg::OP_LBU: rsp_data = {24'd0, sel_byte};
                    lsu_types_pkg::OP_LH:  rsp_data = {{16{sel_half[15]}}, sel_half};
                    lsu_types_pkg::OP_LHU: rsp_data = {16'd0, sel_half};
                    default:               rsp_data = lane_rdata;
                endcase
            end
            // I/O answers word loads only
            mem_map_pkg::REGION_GPI: begin
                if (is_lw) begin
                    rsp_data = {28'd0, gpi_q};
                end
            end
            mem_map_pkg::REGION_GPO: begin
                if (is_lw) begin
                    rsp_data = {28'd0, gpo_q};
                end
            end
            default: rsp_data = '0;
        endcase
    end

    // a never-written lane byte shows up here as X
    always_comb begin
        if (rsp_valid) begin
            a_rsp_known: assert final (!$isunknown(rsp_data))
                else $error("load response data unknown");
        end
    end

endmodule

`default_nettype wire

/* src/mmio_regs.sv */
// ====================
// input sampling register and
// output register
// ====================

`default_nettype none

module mmio_regs (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire mem_map_pkg::gpio_t gpi,
    input  wire logic               gpo_we,
    input  wire mem_map_pkg::gpio_t gpo_data,
    output mem_map_pkg::gpio_t      gpi_q,
    output mem_map_pkg::gpio_t      gpo_q
);

    // pins sampled every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_q <= '0;
        end else begin
            gpi_q <= gpi;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo_q <= '0;
        end else if (gpo_we) begin
            gpo_q <= gpo_data;
        end
    end

endmodule

`default_nettype wire

/* src/dmem_lane.sv */
// ====================
// one byte-wide data memory bank
// ====================

`default_nettype none

`include "lsu_macros.svh"

module dmem_lane (
    input  wire logic                    clk,
    input  wire logic                    we,
    input  wire logic [`LSU_LANE_AW-1:0] addr,
    input  wire logic [7:0]              wdata,
    output logic [7:0]                   rdata
);

    logic [7:0] mem [0:`LSU_LANE_DEPTH-1];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    // write enable never X
    a_we_known: assert property (
        @(posedge clk)
        !$isunknown(we)
    ) else $error("lane write enable unknown");

endmodule

`default_nettype wire

/* src/store_aligner.sv */
// ====================
// region decode, store lane alignment
// and pending-load register
// ====================

`default_nettype none

`include "lsu_macros.svh"

module store_aligner (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    req_valid,
    input  wire lsu_types_pkg::lsu_req_t req,
    output lsu_types_pkg::lane_wr_t      lane_wr,
    output logic                         gpo_we,
    output mem_map_pkg::gpio_t           gpo_data,
    output lsu_types_pkg::pend_load_t    pend
);

    logic [31:0]           dmem_off;
    logic [1:0]            offset;
    mem_map_pkg::region_e  region;
    logic                  is_load;
    logic                  is_store;
    logic [`LSU_LANES-1:0] store_mask;

    assign dmem_off = req.addr - `LSU_DMEM_BASE;
    assign offset   = req.addr[1:0];

    // ====================
    // decode
    // ====================

    // the only place the address map is looked at
    always_comb begin
        if (dmem_off < `LSU_DMEM_BYTES) begin
            region = mem_map_pkg::REGION_DMEM;
        end else if (req.addr == `LSU_GPI_ADDR) begin
            region = mem_map_pkg::REGION_GPI;
        end else if (req.addr == `LSU_GPO_ADDR) begin
            region = mem_map_pkg::REGION_GPO;
        end else begin
            region = mem_map_pkg::REGION_NONE;
        end
    end

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        store_mask = '0;
        case (req.op)
            lsu_types_pkg::OP_LB, lsu_types_pkg::OP_LH, lsu_types_pkg::OP_LW,
            lsu_types_pkg::OP_LBU, lsu_types_pkg::OP_LHU: begin
                is_load = 1'b1;
            end
            lsu_types_pkg::OP_SB: begin
                is_store   = 1'b1;
                store_mask = 4'b0001 << offset;
            end
            lsu_types_pkg::OP_SH: begin
                is_store = 1'b1;
                // halfword at offset 3 would straddle the word, dropped
                if (offset != 2'd3) begin
                    store_mask = 4'b0011 << offset;
                end
            end
            lsu_types_pkg::OP_SW: begin
                is_store   = 1'b1;
                store_mask = 4'b1111;
            end
            default: begin
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

    // ====================
    // store path
    // ====================

    always_comb begin
        lane_wr.we   = (req_valid && region == mem_map_pkg::REGION_DMEM) ? store_mask : '0;
        lane_wr.data = req.wdata << {offset, 3'b000};
        lane_wr.addr = dmem_off[`LSU_LANE_AW+1:2];
        if (req.op == lsu_types_pkg::OP_SW) begin
            lane_wr.data = req.wdata;
        end
    end

    // any store size reaches the output register
    assign gpo_we   = req_valid && is_store && (region == mem_map_pkg::REGION_GPO);
    assign gpo_data = req.wdata[3:0];

    // load record, consumed by the extractor one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            pend.valid  <= req_valid && is_load;
            pend.op     <= req.op;
            pend.offset <= offset;
            pend.region <= region;
        end
    end

    a_legal_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> (is_load || is_store)
    ) else $error("illegal op 0x%0h on a strobed request", req.op);

endmodule

`default_nettype wire

/* src/lsu_types_pkg.sv */
// ====================
// operation encoding, request, lane write
// and pending-load types
// ====================

`default_nettype none

`include "lsu_macros.svh"

package lsu_types_pkg;

    typedef logic [31:0] word_t;

    // bit 3 set for stores
    typedef enum logic [3:0] {
        OP_LB  = 4'h0,
        OP_LH  = 4'h1,
        OP_LW  = 4'h2,
        OP_LBU = 4'h4,
        OP_LHU = 4'h5,
        OP_SB  = 4'h8,
        OP_SH  = 4'h9,
        OP_SW  = 4'ha
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e op;
        word_t   addr;
        word_t   wdata;
    } lsu_req_t;

    // shared by all banks, one we bit and one byte per lane
    typedef struct packed {
        logic [`LSU_LANES-1:0]        we;
        logic [`LSU_LANES-1:0][7:0]   data;
        logic [`LSU_LANE_AW-1:0]      addr;
    } lane_wr_t;

    typedef struct packed {
        logic                  valid;
        lsu_op_e               op;
        logic [1:0]            offset;
        mem_map_pkg::region_e  region;
    } pend_load_t;

endpackage

`default_nettype wire

/* src/mem_map_pkg.sv */
// ====================
// region encoding and I/O nibble type
// ====================

`default_nettype none

package mem_map_pkg;

    // region hit by a request address
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_DMEM = 2'd1,
        REGION_GPI  = 2'd2,
        REGION_GPO  = 2'd3
    } region_e;

    // one 4-bit I/O port
    typedef logic [3:0] gpio_t;

endpackage

`default_nettype wire

/* src/lsu_macros.svh */
// ====================
// address map, lane count and bank depth
// for the load/store unit
// ====================

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// byte lanes per data word
`define LSU_LANES       4

// data memory size and per-lane depth
`define LSU_DMEM_BYTES  4096
`define LSU_LANE_DEPTH  1024
`define LSU_LANE_AW     10

// memory map
`define LSU_DMEM_BASE   32'h0000_8000
`define LSU_GPI_ADDR    32'h0000_F000
`define LSU_GPO_ADDR    32'h0000_F004

`endif
